/* dv/mask_alu_chk.sv */
`timescale 1ns/1ps

module mask_alu_chk (
  input logic                clk,
  input logic                arst_n,
  input logic                uop_valid,
  input logic                result_valid,
  input mask_alu_pkg::vreg_t result_data
);
  import mask_alu_pkg::*;

  // nothing comes out while in reset
  reset_quiet: assert property (@(posedge clk) !arst_n |-> !result_valid)
    else $error("result_valid high while reset is asserted");

  // every result comes from a strobe one cycle earlier
  valid_follows_uop: assert property (
    @(posedge clk) disable iff (!arst_n) result_valid |-> $past(uop_valid))
    else $error("result_valid without a micro-op in the previous cycle");

  result_known: assert property (
    @(posedge clk) disable iff (!arst_n) result_valid |-> !$isunknown(result_data))
    else $error("result_data has unknown bits while result_valid is high");

endmodule

bind mask_result_stage mask_alu_chk mask_alu_chk_inst (
  .clk          (clk),
  .arst_n       (arst_n),
  .uop_valid    (uop_valid),
  .result_valid (result_valid),
  .result_data  (result_data)
);

/* dv/mask_alu_tb.sv */
`timescale 1ns/1ps

module mask_alu_tb;
  import mask_alu_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_ROWS     = 320;
  localparam int RANDOM_ROWS  = 200;

  typedef struct packed {
    logic       uop_valid;
    mask_op_e   op;
    rob_entry_t rob_entry;
    vstart_t    vstart;
    vl_t        vl;
    logic       vm;
    vreg_t      v0_data;
    vreg_t      vd_data;
    vreg_t      vs1_data;
    vreg_t      vs2_data;
    logic       v0_valid;
    logic       vd_valid;
    logic       vs1_valid;
    logic       vs2_valid;
  } row_t;

  logic       clk;
  logic       arst_n;
  logic       uop_valid;
  mask_op_e   op;
  rob_entry_t rob_entry;
  vstart_t    vstart;
  vl_t        vl;
  logic       vm;
  vreg_t      v0_data;
  logic       v0_valid;
  vreg_t      vd_data;
  logic       vd_valid;
  vreg_t      vs1_data;
  logic       vs1_valid;
  vreg_t      vs2_data;
  logic       vs2_valid;
  logic       result_valid;
  rob_entry_t result_rob_entry;
  vreg_t      result_data;

  row_t       rows      [MAX_ROWS];
  string      row_name  [MAX_ROWS];
  logic       exp_valid [MAX_ROWS];
  rob_entry_t exp_rob   [MAX_ROWS];
  vreg_t      exp_data  [MAX_ROWS];
  int         num_rows;
  row_t       cur;
  rob_entry_t last_rob;
  vreg_t      last_data;

  mask_alu mask_alu_inst (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic vreg_t rand_vreg();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic bit is_logic_op(mask_op_e o);
    return o inside {MASK_ANDN, MASK_AND, MASK_OR, MASK_XOR,
                     MASK_ORN, MASK_NAND, MASK_NOR, MASK_XNOR};
  endfunction

  function automatic bit operands_ready(row_t r);
    case (r.op)
      MASK_CPOP, MASK_FIRST: return !r.vs1_valid && r.vs2_valid && (r.vm || r.v0_valid);
      MASK_SBF, MASK_SIF, MASK_SOF: begin
        return !r.vs1_valid && r.vs2_valid && (r.vm || (r.vd_valid && r.v0_valid));
      end
      default: return r.vs1_valid && r.vs2_valid && r.vd_valid && r.vm;
    endcase
  endfunction

  // bit-serial reference of the mask unit
  function automatic vreg_t expected_result(row_t r);
    vreg_t res;
    logic  a;
    logic  b;
    int    first;
    int    count;
    res   = '0;
    first = -1;
    count = 0;
    if (is_logic_op(r.op)) begin
      for (int i = 0; i < VLEN; i++) begin
        a = r.vs2_data[i];
        b = r.vs1_data[i];
        case (r.op)
          MASK_ANDN: res[i] = a & ~b;
          MASK_AND:  res[i] = a & b;
          MASK_OR:   res[i] = a | b;
          MASK_XOR:  res[i] = a ^ b;
          MASK_ORN:  res[i] = a | ~b;
          MASK_NAND: res[i] = ~(a & b);
          MASK_NOR:  res[i] = ~(a | b);
          default:   res[i] = ~(a ^ b);
        endcase
        if (i < int'(r.vstart)) res[i] = r.vd_data[i];
      end
      return res;
    end
    // source bits below vl that v0 leaves active
    for (int i = 0; i < VLEN; i++) begin
      if (r.vs2_data[i] && (i < int'(r.vl)) && (r.vm || r.v0_data[i])) begin
        count++;
        if (first < 0) first = i;
      end
    end
    case (r.op)
      MASK_CPOP:  res = vreg_t'(count);
      MASK_FIRST: res = (first < 0) ? '1 : vreg_t'(first);
      default: begin
        for (int i = 0; i < VLEN; i++) begin
          case (r.op)
            MASK_SBF: res[i] = (first < 0) || (i < first);
            MASK_SIF: res[i] = (first < 0) || (i <= first);
            default:  res[i] = (i == first);
          endcase
          if (!r.vm && (i < int'(r.vl)) && !r.v0_data[i]) res[i] = r.vd_data[i];
        end
      end
    endcase
    return res;
  endfunction

  task automatic new_row(mask_op_e o);
    cur.uop_valid = 1'b1;
    cur.op        = o;
    cur.rob_entry = '0;
    cur.vstart    = '0;
    cur.vl        = vl_t'(VLEN);
    cur.vm        = 1'b1;
    cur.v0_data   = rand_vreg();
    cur.vd_data   = rand_vreg();
    cur.vs1_data  = rand_vreg();
    cur.vs2_data  = rand_vreg();
    cur.v0_valid  = 1'b1;
    cur.vd_valid  = 1'b1;
    cur.vs1_valid = is_logic_op(o);
    cur.vs2_valid = 1'b1;
  endtask

  // store the row with its expected outputs one cycle later
  task automatic push_row(string name);
    cur.rob_entry      = rob_entry_t'(num_rows);
    rows[num_rows]     = cur;
    row_name[num_rows] = name;
    if (cur.uop_valid && operands_ready(cur)) begin
      last_rob            = cur.rob_entry;
      last_data           = expected_result(cur);
      exp_valid[num_rows] = 1'b1;
    end else begin
      exp_valid[num_rows] = 1'b0;
    end
    exp_rob[num_rows]  = last_rob;
    exp_data[num_rows] = last_data;
    num_rows++;
  endtask

  task automatic build_table();
    mask_op_e o;
    for (int k = 0; k < 8; k++) begin
      o = mask_op_e'(4'(k));
      for (int j = 0; j < 3; j++) begin
        new_row(o);
        cur.vstart = (j == 0) ? '0 : ((j == 1) ? vstart_t'(VLEN / 2) : vstart_t'(VLEN - 1));
        push_row($sformatf("%s vstart=%0d", o.name(), cur.vstart));
      end
    end
    for (int k = 8; k < 11; k++) begin
      o = mask_op_e'(4'(k));
      for (int m = 0; m < 2; m++) begin
        for (int s = 0; s < 3; s++) begin
          new_row(o);
          cur.vm = (m == 0);
          cur.vl = vl_t'($urandom_range(0, VLEN));
          if (s == 1) cur.vs2_data = '0;
          if (s == 2) cur.vs2_data = vreg_t'(1) << $urandom_range(0, VLEN - 1);
          push_row($sformatf("%s vm=%0b src=%0d vl=%0d", o.name(), cur.vm, s, cur.vl));
        end
      end
    end
    for (int k = 11; k < 13; k++) begin
      o = mask_op_e'(4'(k));
      for (int j = 0; j < 6; j++) begin
        new_row(o);
        cur.vm = (j < 3);
        case (j % 3)
          0:       cur.vl = '0;
          1:       cur.vl = vl_t'(VLEN);
          default: cur.vl = vl_t'($urandom_range(1, VLEN - 1));
        endcase
        push_row($sformatf("%s vm=%0b vl=%0d", o.name(), cur.vm, cur.vl));
      end
    end
    new_row(MASK_FIRST);
    cur.vm      = 1'b0;
    cur.v0_data = '0;
    push_row("MASK_FIRST empty masked source");
    // one required valid missing per op
    for (int k = 0; k < 13; k++) begin
      o = mask_op_e'(4'(k));
      new_row(o);
      case (k)
        8:       cur.vs2_valid = 1'b0;
        9:       cur.vs1_valid = 1'b1;
        10: begin
          cur.vm       = 1'b0;
          cur.vd_valid = 1'b0;
        end
        11: begin
          cur.vm       = 1'b0;
          cur.v0_valid = 1'b0;
        end
        12:      cur.vs2_valid = 1'b0;
        default: begin
          if (k % 2 == 0) cur.vd_valid = 1'b0;
          else cur.vs1_valid = 1'b0;
        end
      endcase
      push_row($sformatf("%s missing operand", o.name()));
    end
    for (int k = 0; k < 8; k++) begin
      o = mask_op_e'(4'(k));
      new_row(o);
      cur.vm = 1'b0;
      push_row($sformatf("%s with vm low", o.name()));
    end
    new_row(MASK_XOR);
    cur.uop_valid = 1'b0;
    push_row("idle cycle holds result");
    for (int n = 0; n < RANDOM_ROWS; n++) begin
      o = mask_op_e'(4'($urandom_range(0, 12)));
      new_row(o);
      cur.vm     = ($urandom_range(0, 3) != 0);
      cur.vstart = vstart_t'($urandom_range(0, VLEN - 1));
      cur.vl     = vl_t'($urandom_range(0, VLEN));
      if ($urandom_range(0, 9) == 0) cur.uop_valid = 1'b0;
      if ($urandom_range(0, 9) == 0) cur.v0_valid = 1'b0;
      if ($urandom_range(0, 9) == 0) cur.vd_valid = ~cur.vd_valid;
      if ($urandom_range(0, 9) == 0) cur.vs1_valid = ~cur.vs1_valid;
      if ($urandom_range(0, 9) == 0) cur.vs2_valid = 1'b0;
      push_row($sformatf("random %0d %s", n, o.name()));
    end
  endtask

  task automatic check_valid(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAIL %s: result_valid expected %0b, actual %0b", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "result_valid mismatch");
    end
  endtask

  task automatic check_rob(string name, rob_entry_t expected, rob_entry_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: result_rob_entry expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "result_rob_entry mismatch");
    end
  endtask

  task automatic check_data(string name, vreg_t expected, vreg_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: result_data expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "result_data mismatch");
    end
  endtask

  task automatic drive_row(int i);
    uop_valid = rows[i].uop_valid;
    op        = rows[i].op;
    rob_entry = rows[i].rob_entry;
    vstart    = rows[i].vstart;
    vl        = rows[i].vl;
    vm        = rows[i].vm;
    v0_data   = rows[i].v0_data;
    v0_valid  = rows[i].v0_valid;
    vd_data   = rows[i].vd_data;
    vd_valid  = rows[i].vd_valid;
    vs1_data  = rows[i].vs1_data;
    vs1_valid = rows[i].vs1_valid;
    vs2_data  = rows[i].vs2_data;
    vs2_valid = rows[i].vs2_valid;
  endtask

  task automatic check_row(int i);
    check_valid(row_name[i], exp_valid[i], result_valid);
    check_rob(row_name[i], exp_rob[i], result_rob_entry);
    check_data(row_name[i], exp_data[i], result_data);
  endtask

  initial begin
    void'($urandom(33635));
    arst_n    = 1'b0;
    uop_valid = 1'b0;
    op        = MASK_AND;
    rob_entry = '0;
    vstart    = '0;
    vl        = '0;
    vm        = 1'b1;
    v0_data   = '0;
    v0_valid  = 1'b0;
    vd_data   = '0;
    vd_valid  = 1'b0;
    vs1_data  = '0;
    vs1_valid = 1'b0;
    vs2_data  = '0;
    vs2_valid = 1'b0;
    num_rows  = 0;
    last_rob  = '0;
    last_data = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_valid("after reset", 1'b0, result_valid);
    check_rob("after reset", '0, result_rob_entry);
    check_data("after reset", '0, result_data);
    // each row is checked one cycle after it is driven
    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk);
      #2;
      if (i > 0) check_row(i - 1);
      drive_row(i);
    end
    @(posedge clk);
    #2;
    check_row(num_rows - 1);
    $display("All tests passed");
    $finish;
  end

  initial begin
    #1;
    repeat (num_rows + RESET_CYCLES + 10) @(posedge clk);
    $display("watchdog expired before all rows were checked");
    $display("Some tests failed");
    $fatal(1, "timeout");
  end

endmodule

/* run.sh */
#!/bin/sh
# build the mask ALU testbench and run it, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
  --top-module mask_alu_tb \
  -f sources.f \
  -o mask_alu_sim \
  && ./obj_dir/mask_alu_sim \
  || exit 1

/* source/mask_alu.sv */
`timescale 1ns/1ps

module mask_alu (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     uop_valid,
  input  mask_alu_pkg::mask_op_e   op,
  input  mask_alu_pkg::rob_entry_t rob_entry,
  input  mask_alu_pkg::vstart_t    vstart,
  input  mask_alu_pkg::vl_t        vl,
  input  logic                     vm,
  input  mask_alu_pkg::vreg_t      v0_data,
  input  logic                     v0_valid,
  input  mask_alu_pkg::vreg_t      vd_data,
  input  logic                     vd_valid,
  input  mask_alu_pkg::vreg_t      vs1_data,
  input  logic                     vs1_valid,
  input  mask_alu_pkg::vreg_t      vs2_data,
  input  logic                     vs2_valid,
  output logic                     result_valid,
  output mask_alu_pkg::rob_entry_t result_rob_entry,
  output mask_alu_pkg::vreg_t      result_data
);
  import mask_alu_pkg::*;

  vreg_t logic_data;
  vreg_t scan_data;

  // bitwise mask ops
  mask_logic_unit mask_logic_unit_inst (
    .op         (op),
    .vstart     (vstart),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .vd_data    (vd_data),
    .logic_data (logic_data)
  );

  // set-first, count and find-first
  mask_scan_unit mask_scan_unit_inst (
    .op        (op),
    .vl        (vl),
    .vm        (vm),
    .v0_data   (v0_data),
    .vd_data   (vd_data),
    .vs2_data  (vs2_data),
    .scan_data (scan_data)
  );

  mask_result_stage mask_result_stage_inst (
    .clk              (clk),
    .arst_n           (arst_n),
    .uop_valid        (uop_valid),
    .vm               (vm),
    .op               (op),
    .rob_entry        (rob_entry),
    .v0_valid         (v0_valid),
    .vd_valid         (vd_valid),
    .vs1_valid        (vs1_valid),
    .vs2_valid        (vs2_valid),
    .logic_data       (logic_data),
    .scan_data        (scan_data),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

/* source/mask_alu_pkg.sv */
package mask_alu_pkg;

  // vector register geometry
  localparam int VLEN            = 128;
  localparam int VL_WIDTH        = $clog2(VLEN) + 1;
  localparam int VSTART_WIDTH    = $clog2(VLEN);

  // reorder buffer tag
  localparam int ROB_DEPTH_WIDTH = 4;

  // population count partial-sum group size
  localparam int CPOP_CHUNK      = 16;

  typedef logic [VLEN-1:0]            vreg_t;
  typedef logic [VL_WIDTH-1:0]        vl_t;
  typedef logic [VSTART_WIDTH-1:0]    vstart_t;
  typedef logic [ROB_DEPTH_WIDTH-1:0] rob_entry_t;

  // mask unit micro-op
  typedef enum logic [3:0] {
    MASK_ANDN  = 4'd0,
    MASK_AND   = 4'd1,
    MASK_OR    = 4'd2,
    MASK_XOR   = 4'd3,
    MASK_ORN   = 4'd4,
    MASK_NAND  = 4'd5,
    MASK_NOR   = 4'd6,
    MASK_XNOR  = 4'd7,
    MASK_SBF   = 4'd8,
    MASK_SIF   = 4'd9,
    MASK_SOF   = 4'd10,
    MASK_CPOP  = 4'd11,
    MASK_FIRST = 4'd12
  } mask_op_e;

endpackage

/* source/mask_logic_unit.sv */
`timescale 1ns/1ps

module mask_logic_unit (
  input  mask_alu_pkg::mask_op_e op,
  input  mask_alu_pkg::vstart_t  vstart,
  input  mask_alu_pkg::vreg_t    vs1_data,
  input  mask_alu_pkg::vreg_t    vs2_data,
  input  mask_alu_pkg::vreg_t    vd_data,
  output mask_alu_pkg::vreg_t    logic_data
);
  import mask_alu_pkg::*;

  vreg_t op_result;
  vreg_t prefix_mask;
  logic  is_logic_op;

  // vs2 is the first operand
  always_comb begin
    is_logic_op = 1'b1;
    case (op)
      MASK_ANDN: op_result = vs2_data & ~vs1_data;
      MASK_AND:  op_result = vs2_data & vs1_data;
      MASK_OR:   op_result = vs2_data | vs1_data;
      MASK_XOR:  op_result = vs2_data ^ vs1_data;
      MASK_ORN:  op_result = vs2_data | ~vs1_data;
      MASK_NAND: op_result = ~(vs2_data & vs1_data);
      MASK_NOR:  op_result = ~(vs2_data | vs1_data);
      MASK_XNOR: op_result = ~(vs2_data ^ vs1_data);
      default: begin
        op_result   = '0;
        is_logic_op = 1'b0;
      end
    endcase
  end

  // bits below vstart
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      prefix_mask[i] = (i < int'(vstart));
    end
  end

  // prefix keeps the old destination
  always_comb begin
    if (is_logic_op) begin
      logic_data = (op_result & ~prefix_mask) | (vd_data & prefix_mask);
    end else begin
      logic_data = '0;
    end
  end

endmodule

/* source/mask_result_stage.sv */
`timescale 1ns/1ps

module mask_result_stage (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     uop_valid,
  input  logic                     vm,
  input  mask_alu_pkg::mask_op_e   op,
  input  mask_alu_pkg::rob_entry_t rob_entry,
  input  logic                     v0_valid,
  input  logic                     vd_valid,
  input  logic                     vs1_valid,
  input  logic                     vs2_valid,
  input  mask_alu_pkg::vreg_t      logic_data,
  input  mask_alu_pkg::vreg_t      scan_data,
  output logic                     result_valid,
  output mask_alu_pkg::rob_entry_t result_rob_entry,
  output mask_alu_pkg::vreg_t      result_data
);
  import mask_alu_pkg::*;

  logic  is_logic_class;
  logic  is_set_class;
  logic  is_count_class;
  logic  logic_ok;
  logic  set_ok;
  logic  count_ok;
  logic  accept;
  vreg_t sel_data;

  // opcode class
  always_comb begin
    is_logic_class = 1'b0;
    is_set_class   = 1'b0;
    is_count_class = 1'b0;
    case (op)
      MASK_ANDN, MASK_AND, MASK_OR, MASK_XOR,
      MASK_ORN, MASK_NAND, MASK_NOR, MASK_XNOR: begin
        is_logic_class = 1'b1;
      end
      MASK_SBF, MASK_SIF, MASK_SOF: begin
        is_set_class = 1'b1;
      end
      MASK_CPOP, MASK_FIRST: begin
        is_count_class = 1'b1;
      end
      default: begin
        is_logic_class = 1'b0;
      end
    endcase
  end

  // operand readiness per class
  assign logic_ok = vs1_valid & vs2_valid & vd_valid & vm;
  assign count_ok = ~vs1_valid & vs2_valid & (vm | v0_valid);
  assign set_ok   = ~vs1_valid & vs2_valid & (vm | (vd_valid & v0_valid));

  assign accept = uop_valid & ((is_logic_class & logic_ok) |
                               (is_set_class & set_ok) |
                               (is_count_class & count_ok));

  assign sel_data = is_logic_class ? logic_data : scan_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid     <= 1'b0;
      result_rob_entry <= '0;
      result_data      <= '0;
    end else begin
      result_valid <= accept;
      // hold last result when idle
      if (accept) begin
        result_rob_entry <= rob_entry;
        result_data      <= sel_data;
      end
    end
  end

endmodule

/* source/mask_scan_unit.sv */
`timescale 1ns/1ps

module mask_scan_unit (
  input  mask_alu_pkg::mask_op_e op,
  input  mask_alu_pkg::vl_t      vl,
  input  logic                   vm,
  input  mask_alu_pkg::vreg_t    v0_data,
  input  mask_alu_pkg::vreg_t    vd_data,
  input  mask_alu_pkg::vreg_t    vs2_data,
  output mask_alu_pkg::vreg_t    scan_data
);
  import mask_alu_pkg::*;

  localparam int NUM_CHUNKS = VLEN / CPOP_CHUNK;
  localparam int PART_WIDTH = $clog2(CPOP_CHUNK) + 1;

  vreg_t tail_mask;
  vreg_t masked_src;
  vreg_t src_minus1;
  vreg_t first1;
  vreg_t sbf_data;
  vreg_t sif_data;
  vreg_t sof_data;
  vreg_t set_data;
  vreg_t fill_mask;
  logic  src_zero;

  logic [VSTART_WIDTH-1:0]                  first_idx;
  logic [NUM_CHUNKS-1:0][PART_WIDTH-1:0]    cpop_part;
  logic [VL_WIDTH-1:0]                      cpop_total;

  // elements below vl are active
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      tail_mask[i] = (i < int'(vl));
    end
  end

  assign masked_src = vm ? (vs2_data & tail_mask) : (vs2_data & tail_mask & v0_data);
  assign src_zero   = (masked_src == '0);

  // lowest set bit and the masks around it
  assign src_minus1 = masked_src - vreg_t'(1);
  assign first1     = masked_src & ~src_minus1;
  assign sbf_data   = src_minus1 & ~masked_src;
  assign sif_data   = src_minus1 ^ masked_src;
  assign sof_data   = first1;

  // one-hot to index
  always_comb begin
    first_idx = '0;
    for (int i = 0; i < VLEN; i++) begin
      if (first1[i]) begin
        first_idx = first_idx | VSTART_WIDTH'(i);
      end
    end
  end

  // partial counts per chunk and their total
  always_comb begin
    for (int c = 0; c < NUM_CHUNKS; c++) begin
      cpop_part[c] = '0;
      for (int b = 0; b < CPOP_CHUNK; b++) begin
        cpop_part[c] = cpop_part[c] + PART_WIDTH'(masked_src[c*CPOP_CHUNK+b]);
      end
    end
  end

  always_comb begin
    cpop_total = '0;
    for (int c = 0; c < NUM_CHUNKS; c++) begin
      cpop_total = cpop_total + VL_WIDTH'(cpop_part[c]);
    end
  end

  // inactive body elements come from vd
  assign fill_mask = vm ? '0 : (tail_mask & ~v0_data);

  always_comb begin
    case (op)
      MASK_SBF: set_data = sbf_data;
      MASK_SIF: set_data = sif_data;
      default:  set_data = sof_data;
    endcase
  end

  always_comb begin
    case (op)
      MASK_SBF,
      MASK_SIF,
      MASK_SOF: begin
        scan_data = (set_data & ~fill_mask) | (vd_data & fill_mask);
      end
      MASK_CPOP: begin
        scan_data = vreg_t'(cpop_total);
      end
      MASK_FIRST: begin
        scan_data = src_zero ? '1 : vreg_t'(first_idx);
      end
      default: begin
        scan_data = '0;
      end
    endcase
  end

endmodule

/* sources.f */
source/mask_alu_pkg.sv
source/mask_logic_unit.sv
source/mask_scan_unit.sv
source/mask_result_stage.sv
source/mask_alu.sv
dv/mask_alu_chk.sv
dv/mask_alu_tb.sv
